//--- Makefile
TOP := xr_subsys_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f files.f --top-module $(TOP)

sim:
	verilator --binary --assert --timescale 1ns/1ps -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- files.f
+incdir+verilog
verilog/xr_pkg.sv
verilog/xr_dpram.sv
verilog/xr_regs.sv
verilog/copper.sv
verilog/video_fetch.sv
verilog/xr_mem_arb.sv
verilog/xr_subsys_top.sv
test/xr_subsys_properties.sv
test/xr_subsys_tb.sv

//--- test/xr_subsys_properties.sv
`default_nettype none

`include "xr_defs.svh"

module xr_subsys_properties (
    input wire logic clk,
    input wire logic rst_n_i,
    input wire logic host_sel_i,
    input wire logic host_ack_i,
    input wire logic copp_sel_i,
    input wire logic copp_ack_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // cycles the host has waited on the current access
    logic [3:0] host_wait;

    always_ff @(posedge clk) begin
        if (!rst_n_i || !host_sel_i || host_ack_i) begin
            host_wait <= '0;
        end else begin
            host_wait <= host_wait + 4'd1;
        end
    end

    ack_after_select: assert property (@(posedge clk) disable iff (!rst_n_i)
        !host_sel_i |=> !host_ack_i)
        else $error("host ack without a select in the cycle before");

    // the copper keeps its select up until it sees the ack
    copper_ack_next: assert property (@(posedge clk) disable iff (!rst_n_i)
        copp_sel_i && !copp_ack_i |=> copp_sel_i && copp_ack_i)
        else $error("copper write not held and acknowledged on the next cycle");

    host_ack_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
        host_wait <= 4'(`XR_ACK_TIMEOUT + 1))
        else $error("host access waited past the timeout");

endmodule

bind xr_mem_arb xr_subsys_properties u_xr_subsys_properties (
    .clk(clk), .rst_n_i(rst_n_i),
    .host_sel_i(xr_sel_i), .host_ack_i(xr_ack_o),
    .copp_sel_i(copp_xr_sel_i), .copp_ack_i(copp_xr_ack_o)
);

`default_nettype wire

//--- test/xr_subsys_tb.sv
`default_nettype none

`include "xr_defs.svh"

module xr_subsys_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD   = 20;
    localparam int ACK_LIMIT     = `XR_ACK_TIMEOUT + 1;
    localparam int COPP_START    = 4;
    localparam int COPPER_CYCLES = 64;
    localparam int VID_LEN       = 6;
    localparam int PIXEL_COUNT   = 3 * VID_LEN;
    localparam int BUSY_READS    = 4;

    typedef struct packed {
        logic             wr;
        xr_pkg::xr_addr_t addr;
        xr_pkg::xr_word_t data;
        xr_pkg::xr_word_t expected;
    } host_op_t;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             xr_sel;
    logic             xr_wr;
    xr_pkg::xr_addr_t xr_addr;
    xr_pkg::xr_word_t xr_wdata;
    logic             xr_ack;
    xr_pkg::xr_word_t xr_rdata;
    xr_pkg::xr_word_t pixel;
    xr_pkg::xr_word_t pixel_b;
    logic             pixel_valid;
    logic             copper_busy;

    host_op_t         ops[$];
    int               phase_end[4];
    // expected contents, keyed by XR address
    xr_pkg::xr_word_t ref_mem[xr_pkg::xr_addr_t];
    integer           seed;
    int               cycle_count = 0;
    int               cycle_limit = 0;

    xr_subsys_top u_xr_subsys_top (
        .clk(clk), .rst_n_i(rst_n),
        .xr_sel_i(xr_sel), .xr_wr_i(xr_wr), .xr_addr_i(xr_addr), .xr_data_i(xr_wdata),
        .xr_ack_o(xr_ack), .xr_data_o(xr_rdata),
        .pixel_o(pixel), .pixel_b_o(pixel_b), .pixel_valid_o(pixel_valid),
        .copper_busy_o(copper_busy)
    );

    always #HALF_PERIOD clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "stopping on the first failure");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
            abort_run();
        end
    endtask

    function automatic xr_pkg::xr_addr_t color_xr_addr(input logic table_b, input int idx);
        return {`XR_AREA_COLOR, 4'b0000, table_b, 8'(idx)};
    endfunction

    function automatic xr_pkg::xr_addr_t tile_xr_addr(input int idx);
        return {`XR_AREA_TILE, 13'(idx)};
    endfunction

    // bit 0 clear is the target address, set is the data
    function automatic xr_pkg::xr_addr_t copper_xr_addr(input int idx, input logic lo);
        return {`XR_AREA_COPP, 4'b0000, 8'(idx), lo};
    endfunction

    function automatic xr_pkg::xr_word_t random_word();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic void add_write(input xr_pkg::xr_addr_t addr, input xr_pkg::xr_word_t data);
        host_op_t op;
        op.wr       = 1'b1;
        op.addr     = addr;
        op.data     = data;
        op.expected = data;
        ref_mem[addr] = data;
        ops.push_back(op);
    endfunction

    function automatic void add_read(input xr_pkg::xr_addr_t addr);
        host_op_t op;
        op.wr       = 1'b0;
        op.addr     = addr;
        op.data     = '0;
        op.expected = ref_mem[addr];
        ops.push_back(op);
    endfunction

    function automatic void build_tests();
        xr_pkg::xr_addr_t targets[7];
        xr_pkg::xr_addr_t target;
        xr_pkg::xr_word_t word;
        int               pc;
        // registers clear on reset
        for (int i = 0; i < 8; i++) begin
            ref_mem[16'(i)] = '0;
            add_read(16'(i));
        end
        for (int i = 2; i < 8; i++) begin
            add_write(16'(i), random_word());
        end
        add_write(16'h0004, random_word());
        for (int i = 2; i < 8; i++) begin
            add_read(16'(i));
        end
        for (int i = 0; i < 4; i++) begin
            add_write(color_xr_addr(1'b0, i * 37), random_word());
            add_write(color_xr_addr(1'b1, i * 37), random_word());
            add_write(tile_xr_addr(i * 300 + 5), random_word());
            add_write(copper_xr_addr(i * 60, 1'b0), random_word());
            add_write(copper_xr_addr(i * 60, 1'b1), random_word());
        end
        add_write(tile_xr_addr(1023), random_word());
        for (int i = 0; i < 4; i++) begin
            add_read(color_xr_addr(1'b0, i * 37));
            add_read(color_xr_addr(1'b1, i * 37));
            add_read(tile_xr_addr(i * 300 + 5));
            add_read(copper_xr_addr(i * 60, 1'b0));
            add_read(copper_xr_addr(i * 60, 1'b1));
        end
        add_read(tile_xr_addr(1023));
        phase_end[0] = ops.size();

        // copper program, the command after the stop must never run
        targets = '{16'h0005, color_xr_addr(1'b0, 16), color_xr_addr(1'b1, 16),
                    tile_xr_addr(32), 16'h0006, `XR_STOP_ADDR, 16'h0007};
        for (int i = 0; i < 7; i++) begin
            add_write(copper_xr_addr(COPP_START + i, 1'b0), targets[i]);
            add_write(copper_xr_addr(COPP_START + i, 1'b1), random_word());
        end
        add_write(16'h0000, {7'b0, 8'(COPP_START), 1'b1});
        phase_end[1] = ops.size();
        pc = COPP_START;
        target = ref_mem[copper_xr_addr(pc, 1'b0)];
        while (target != `XR_STOP_ADDR) begin
            ref_mem[target] = ref_mem[copper_xr_addr(pc, 1'b1)];
            pc++;
            target = ref_mem[copper_xr_addr(pc, 1'b0)];
        end
        for (int i = 0; i < 7; i++) begin
            if (targets[i] != `XR_STOP_ADDR) begin
                add_read(targets[i]);
            end
        end
        phase_end[2] = ops.size();

        for (int i = 0; i < 8; i++) begin
            add_write(color_xr_addr(1'b0, 'h40 + i), random_word());
            add_write(color_xr_addr(1'b1, 'h40 + i), random_word());
        end
        for (int t = 0; t < VID_LEN; t++) begin
            word = random_word();
            // low byte picks one of the eight colors above
            add_write(tile_xr_addr(t), {word[15:8], 5'b01000, word[2:0]});
        end
        add_write(16'h0002, 16'(VID_LEN));
        add_write(16'h0001, 16'h0001);
        phase_end[3] = ops.size();
    endfunction

    task automatic host_access(input logic wr, input xr_pkg::xr_addr_t addr,
                               input xr_pkg::xr_word_t data, output xr_pkg::xr_word_t rdata,
                               output int latency);
        logic acked;
        @(posedge clk);
        xr_sel   <= 1'b1;
        xr_wr    <= wr;
        xr_addr  <= addr;
        xr_wdata <= data;
        latency = 0;
        acked   = 1'b0;
        while (!acked) begin
            @(posedge clk);
            latency++;
            @(negedge clk);
            acked = xr_ack;
            if (!acked && latency >= ACK_LIMIT) begin
                $display("host access to %h not acknowledged within %0d cycles", addr, ACK_LIMIT);
                abort_run();
            end
        end
        // read data is valid while ack is high
        rdata = xr_rdata;
        @(posedge clk);
        xr_sel <= 1'b0;
    endtask

    task automatic apply_ops(input int first, input int last);
        xr_pkg::xr_word_t rdata;
        int               latency;
        for (int i = first; i < last; i++) begin
            host_access(ops[i].wr, ops[i].addr, ops[i].data, rdata, latency);
            check_equal(32'(latency), 32'd1, $sformatf("ack latency at %h", ops[i].addr));
            if (!ops[i].wr) begin
                check_equal(32'(rdata), 32'(ops[i].expected),
                            $sformatf("read of %h", ops[i].addr));
            end
        end
    endtask

    task automatic wait_copper_done();
        int   waited;
        logic started;
        waited  = 0;
        started = 1'b0;
        while (!started) begin
            @(negedge clk);
            waited++;
            started = copper_busy;
            if (!started && waited >= 4) begin
                $display("copper did not start after the enable write");
                abort_run();
            end
        end
        while (copper_busy) begin
            @(negedge clk);
            waited++;
            if (waited > COPPER_CYCLES) begin
                $display("copper still busy after %0d cycles", COPPER_CYCLES);
                abort_run();
            end
        end
    endtask

    task automatic check_pixels(input int count);
        int               seen;
        int               waited;
        int               tile;
        xr_pkg::xr_word_t word;
        seen   = 0;
        waited = 0;
        tile   = 0;
        while (seen < count) begin
            @(negedge clk);
            waited++;
            if (waited > count + 8) begin
                $display("video gave only %0d of %0d pixels", seen, count);
                abort_run();
            end
            if (pixel_valid) begin
                word = ref_mem[tile_xr_addr(tile)];
                check_equal(32'(pixel), 32'(ref_mem[color_xr_addr(1'b0, int'(word[7:0]))]),
                            $sformatf("pixel_o of tile %0d", tile));
                check_equal(32'(pixel_b), 32'(ref_mem[color_xr_addr(1'b1, int'(word[7:0]))]),
                            $sformatf("pixel_b_o of tile %0d", tile));
                tile = (tile + 1) % VID_LEN;
                seen++;
            end
        end
    endtask

    initial begin
        xr_pkg::xr_word_t rdata;
        int               latency;
        seed     = 32'h2161;
        rst_n    = 1'b0;
        xr_sel   = 1'b0;
        xr_wr    = 1'b0;
        xr_addr  = '0;
        xr_wdata = '0;
        build_tests();
        cycle_limit = 4 + ops.size() * (`XR_ACK_TIMEOUT + 4) + COPPER_CYCLES
                    + PIXEL_COUNT + 8 + BUSY_READS * (`XR_ACK_TIMEOUT + 4);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_equal(32'(copper_busy), 32'd0, "copper_busy after reset");
        check_equal(32'(pixel_valid), 32'd0, "pixel_valid after reset");
        apply_ops(0, phase_end[0]);
        apply_ops(phase_end[0], phase_end[1]);
        wait_copper_done();
        apply_ops(phase_end[1], phase_end[2]);
        apply_ops(phase_end[2], phase_end[3]);
        check_pixels(PIXEL_COUNT);
        // video holds the tile port, so these reads end on the timeout ack
        for (int i = 0; i < BUSY_READS; i++) begin
            host_access(1'b0, tile_xr_addr(i), '0, rdata, latency);
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/copper.sv
`default_nettype none

`include "xr_defs.svh"

module copper (
    input  wire logic               clk,
    input  wire logic               rst_n_i,
    input  wire logic               copp_en_i,
    input  wire xr_pkg::copp_addr_t copp_start_i,
    output logic                    copp_prog_sel_o,
    output xr_pkg::copp_addr_t      copp_prog_addr_o,
    input  wire xr_pkg::copp_word_t copp_prog_data_i,
    output logic                    copp_xr_sel_o,
    output xr_pkg::xr_addr_t        copp_xr_addr_o,
    output xr_pkg::xr_word_t        copp_xr_data_o,
    input  wire logic               copp_xr_ack_i,
    output logic                    copper_busy_o
);

    xr_pkg::copp_state_t state;
    xr_pkg::copp_addr_t  pc;
    xr_pkg::copp_word_t  cmd;
    logic                en_q;

    assign copp_prog_sel_o  = (state == xr_pkg::FETCH);
    assign copp_prog_addr_o = pc;
    assign copp_xr_sel_o    = (state == xr_pkg::WRITE);
    assign copp_xr_addr_o   = cmd[31:16];
    assign copp_xr_data_o   = cmd[15:0];
    assign copper_busy_o    = (state != xr_pkg::IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= xr_pkg::IDLE;
            pc    <= '0;
            en_q  <= 1'b0;
        end else begin
            en_q <= copp_en_i;
            case (state)
                xr_pkg::IDLE: begin
                    // start only on a rising enable
                    if (copp_en_i && !en_q) begin
                        pc    <= copp_start_i;
                        state <= xr_pkg::FETCH;
                    end
                end
                xr_pkg::FETCH: begin
                    // clearing the enable aborts between commands
                    state <= copp_en_i ? xr_pkg::DECODE : xr_pkg::IDLE;
                end
                xr_pkg::DECODE: begin
                    if (copp_prog_data_i[31:16] == `XR_STOP_ADDR) begin
                        state <= xr_pkg::IDLE;
                    end else begin
                        state <= xr_pkg::WRITE;
                    end
                end
                xr_pkg::WRITE: begin
                    if (copp_xr_ack_i) begin
                        pc    <= pc + xr_pkg::copp_addr_t'(1);
                        state <= xr_pkg::FETCH;
                    end
                end
                default: state <= xr_pkg::IDLE;
            endcase
        end
    end

    // program data is only valid in the cycle after the fetch strobe
    always_ff @(posedge clk) begin
        if (state == xr_pkg::DECODE) begin
            cmd <= copp_prog_data_i;
        end
    end

endmodule

`default_nettype wire

//--- verilog/video_fetch.sv
`default_nettype none

`include "xr_defs.svh"

module video_fetch (
    input  wire logic                clk,
    input  wire logic                rst_n_i,
    input  wire logic                vid_en_i,
    input  wire xr_pkg::xr_word_t    vid_len_i,
    output logic                     tile_sel_o,
    output xr_pkg::tile_addr_t       tile_addr_o,
    input  wire xr_pkg::xr_word_t    tile_data_i,
    output logic                     color_sel_o,
    output xr_pkg::color_addr_t      color_addr_o,
    input  wire xr_pkg::xr_word_t    colora_data_i,
    input  wire xr_pkg::xr_word_t    colorb_data_i,
    output xr_pkg::xr_word_t         pixel_o,
    output xr_pkg::xr_word_t         pixel_b_o,
    output logic                     pixel_valid_o
);

    xr_pkg::vid_state_t state;
    xr_pkg::tile_addr_t tile_idx;
    xr_pkg::xr_word_t   tile_next;

    // stage 1 reads a tile every cycle while running
    assign tile_sel_o  = (state == xr_pkg::RUN);
    assign tile_addr_o = tile_idx;
    assign tile_next   = 16'(tile_idx) + 16'd1;

    // stage 2 looks up the low byte of last cycle's tile word
    assign color_addr_o = tile_data_i[`XR_COLOR_AWIDTH-1:0];

    // stage 3 takes both colors straight from the table outputs
    assign pixel_o   = colora_data_i;
    assign pixel_b_o = colorb_data_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state         <= xr_pkg::OFF;
            tile_idx      <= '0;
            color_sel_o   <= 1'b0;
            pixel_valid_o <= 1'b0;
        end else begin
            color_sel_o   <= tile_sel_o;
            pixel_valid_o <= color_sel_o;
            if (state == xr_pkg::OFF) begin
                tile_idx <= '0;
                if (vid_en_i && vid_len_i != '0) begin
                    state <= xr_pkg::RUN;
                end
            end else begin
                if (!vid_en_i) begin
                    state <= xr_pkg::OFF;
                end
                // wrap after the last tile
                if (tile_next >= vid_len_i) begin
                    tile_idx <= '0;
                end else begin
                    tile_idx <= tile_next[`XR_TILE_AWIDTH-1:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/xr_defs.svh
`ifndef XR_DEFS_SVH
`define XR_DEFS_SVH

// memory address widths
`define XR_COLOR_AWIDTH 8
`define XR_TILE_AWIDTH 10
`define XR_COPP_AWIDTH 8

// area codes in address bits 15..13, bit 15 clear selects the registers
`define XR_AREA_COLOR 3'b100
`define XR_AREA_TILE 3'b101
`define XR_AREA_COPP 3'b110

// host select cycles before a forced acknowledge
`define XR_ACK_TIMEOUT 8

// copper target address that ends a program
`define XR_STOP_ADDR 16'hFFFF

`endif

//--- verilog/xr_dpram.sv
`default_nettype none

module xr_dpram #(
    parameter int AWIDTH = 8
) (
    input  wire logic              clk,
    input  wire logic              rd_en_i,
    input  wire logic [AWIDTH-1:0] rd_addr_i,
    output xr_pkg::xr_word_t       rd_data_o,
    input  wire logic              wr_en_i,
    input  wire logic [AWIDTH-1:0] wr_addr_i,
    input  wire xr_pkg::xr_word_t  wr_data_i
);

    xr_pkg::xr_word_t mem [2**AWIDTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // read data holds its value between read strobes
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

`default_nettype wire

//--- verilog/xr_mem_arb.sv
`default_nettype none

`include "xr_defs.svh"

module xr_mem_arb (
    input  wire logic                clk,
    input  wire logic                rst_n_i,
    // host port
    input  wire logic                xr_sel_i,
    input  wire logic                xr_wr_i,
    input  wire xr_pkg::xr_addr_t    xr_addr_i,
    input  wire xr_pkg::xr_word_t    xr_data_i,
    output logic                     xr_ack_o,
    output xr_pkg::xr_word_t         xr_data_o,
    // copper writes
    input  wire logic                copp_xr_sel_i,
    input  wire xr_pkg::xr_addr_t    copp_xr_addr_i,
    input  wire xr_pkg::xr_word_t    copp_xr_data_i,
    output logic                     copp_xr_ack_o,
    // copper program fetch
    input  wire logic                copp_prog_sel_i,
    input  wire xr_pkg::copp_addr_t  copp_prog_addr_i,
    output xr_pkg::copp_word_t       copp_prog_data_o,
    // video reads
    input  wire logic                vid_tile_sel_i,
    input  wire xr_pkg::tile_addr_t  vid_tile_addr_i,
    output xr_pkg::xr_word_t         vid_tile_data_o,
    input  wire logic                vid_color_sel_i,
    input  wire xr_pkg::color_addr_t vid_color_addr_i,
    output xr_pkg::xr_word_t         vid_colora_data_o,
    output xr_pkg::xr_word_t         vid_colorb_data_o,
    // register bus
    output logic                     xreg_wr_o,
    output xr_pkg::xr_addr_t         xreg_addr_o,
    output xr_pkg::xr_word_t         xreg_data_o,
    input  wire xr_pkg::xr_word_t    xreg_data_i
);

    logic                host_regs;
    logic                host_color;
    logic                host_tile;
    logic                host_copp;
    logic                copp_wr_go;
    logic                host_go;
    logic                host_rd;
    logic                host_wr_ok;
    logic                host_rd_ack;
    logic                timed_out;
    logic                wr_any;
    xr_pkg::xr_addr_t    wr_addr;
    xr_pkg::xr_word_t    wr_data;
    logic                color_wr_en;
    logic                tile_wr_en;
    logic                copp_wr_en;
    logic                color_rd_en;
    logic                tile_rd_en;
    logic                copp_rd_en;
    xr_pkg::color_addr_t color_addr;
    xr_pkg::tile_addr_t  tile_addr;
    xr_pkg::copp_addr_t  copp_addr;
    xr_pkg::xr_word_t    reg_rd_q;
    logic [2:0]          ack_timer;

    // host area decode
    assign host_regs  = ~xr_addr_i[15];
    assign host_color = (xr_addr_i[15:13] == `XR_AREA_COLOR);
    assign host_tile  = (xr_addr_i[15:13] == `XR_AREA_TILE);
    assign host_copp  = (xr_addr_i[15:13] == `XR_AREA_COPP);

    // a request is pending until its acknowledge goes out
    assign copp_wr_go = copp_xr_sel_i & ~copp_xr_ack_o;
    assign host_go    = xr_sel_i & ~xr_ack_o;
    assign host_rd    = host_go & ~xr_wr_i;
    assign host_wr_ok = host_go & xr_wr_i & ~copp_wr_go;

    // single write path, copper first
    assign wr_any  = copp_wr_go | host_wr_ok;
    assign wr_addr = copp_wr_go ? copp_xr_addr_i : xr_addr_i;
    assign wr_data = copp_wr_go ? copp_xr_data_i : xr_data_i;

    assign color_wr_en = wr_any & (wr_addr[15:13] == `XR_AREA_COLOR);
    assign tile_wr_en  = wr_any & (wr_addr[15:13] == `XR_AREA_TILE);
    assign copp_wr_en  = wr_any & (wr_addr[15:13] == `XR_AREA_COPP);

    assign xreg_wr_o   = wr_any & ~wr_addr[15];
    assign xreg_addr_o = wr_addr;
    assign xreg_data_o = wr_data;

    // read ports, video and copper fetch win over the host
    assign color_rd_en = vid_color_sel_i | (host_rd & host_color);
    assign color_addr  = vid_color_sel_i ? vid_color_addr_i
                                         : xr_addr_i[`XR_COLOR_AWIDTH-1:0];
    assign tile_rd_en  = vid_tile_sel_i | (host_rd & host_tile);
    assign tile_addr   = vid_tile_sel_i ? vid_tile_addr_i : xr_addr_i[`XR_TILE_AWIDTH-1:0];
    assign copp_rd_en  = copp_prog_sel_i | (host_rd & host_copp);
    assign copp_addr   = copp_prog_sel_i ? copp_prog_addr_i : xr_addr_i[`XR_COPP_AWIDTH:1];

    // register reads share the bus address with copper writes
    assign host_rd_ack = host_rd & ((host_regs & ~copp_wr_go)
                                  | (host_color & ~vid_color_sel_i)
                                  | (host_tile & ~vid_tile_sel_i)
                                  | (host_copp & ~copp_prog_sel_i));

    assign timed_out = host_go & (ack_timer == 3'(`XR_ACK_TIMEOUT - 1));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            xr_ack_o      <= 1'b0;
            copp_xr_ack_o <= 1'b0;
            ack_timer     <= '0;
        end else begin
            copp_xr_ack_o <= copp_wr_go;
            // a timeout ack returns whatever the read mux holds
            xr_ack_o      <= host_wr_ok | host_rd_ack | timed_out;
            if (!xr_sel_i || xr_ack_o) begin
                ack_timer <= '0;
            end else begin
                ack_timer <= ack_timer + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (host_rd & host_regs & ~copp_wr_go) begin
            reg_rd_q <= xreg_data_i;
        end
    end

    always_comb begin
        case (xr_addr_i[15:13])
            `XR_AREA_COLOR: xr_data_o = xr_addr_i[`XR_COLOR_AWIDTH] ? vid_colorb_data_o
                                                                    : vid_colora_data_o;
            `XR_AREA_TILE:  xr_data_o = vid_tile_data_o;
            `XR_AREA_COPP:  xr_data_o = xr_addr_i[0] ? copp_prog_data_o[15:0]
                                                     : copp_prog_data_o[31:16];
            default:        xr_data_o = reg_rd_q;
        endcase
    end

    // address bit 8 picks table B
    xr_dpram #(.AWIDTH(`XR_COLOR_AWIDTH)) u_color_a (
        .clk(clk), .rd_en_i(color_rd_en), .rd_addr_i(color_addr),
        .rd_data_o(vid_colora_data_o),
        .wr_en_i(color_wr_en & ~wr_addr[`XR_COLOR_AWIDTH]),
        .wr_addr_i(wr_addr[`XR_COLOR_AWIDTH-1:0]), .wr_data_i(wr_data)
    );

    xr_dpram #(.AWIDTH(`XR_COLOR_AWIDTH)) u_color_b (
        .clk(clk), .rd_en_i(color_rd_en), .rd_addr_i(color_addr),
        .rd_data_o(vid_colorb_data_o),
        .wr_en_i(color_wr_en & wr_addr[`XR_COLOR_AWIDTH]),
        .wr_addr_i(wr_addr[`XR_COLOR_AWIDTH-1:0]), .wr_data_i(wr_data)
    );

    xr_dpram #(.AWIDTH(`XR_TILE_AWIDTH)) u_tile (
        .clk(clk), .rd_en_i(tile_rd_en), .rd_addr_i(tile_addr),
        .rd_data_o(vid_tile_data_o),
        .wr_en_i(tile_wr_en),
        .wr_addr_i(wr_addr[`XR_TILE_AWIDTH-1:0]), .wr_data_i(wr_data)
    );

    // copper commands split over two halves, bit 0 clear is the high word
    xr_dpram #(.AWIDTH(`XR_COPP_AWIDTH)) u_copp_hi (
        .clk(clk), .rd_en_i(copp_rd_en), .rd_addr_i(copp_addr),
        .rd_data_o(copp_prog_data_o[31:16]),
        .wr_en_i(copp_wr_en & ~wr_addr[0]),
        .wr_addr_i(wr_addr[`XR_COPP_AWIDTH:1]), .wr_data_i(wr_data)
    );

    xr_dpram #(.AWIDTH(`XR_COPP_AWIDTH)) u_copp_lo (
        .clk(clk), .rd_en_i(copp_rd_en), .rd_addr_i(copp_addr),
        .rd_data_o(copp_prog_data_o[15:0]),
        .wr_en_i(copp_wr_en & wr_addr[0]),
        .wr_addr_i(wr_addr[`XR_COPP_AWIDTH:1]), .wr_data_i(wr_data)
    );

endmodule

`default_nettype wire

//--- verilog/xr_pkg.sv
`default_nettype none

`include "xr_defs.svh"

package xr_pkg;

    // XR bus address and data word
    typedef logic [15:0] xr_addr_t;
    typedef logic [15:0] xr_word_t;

    // copper command, target address high and data low
    typedef logic [31:0] copp_word_t;

    // memory indexes
    typedef logic [`XR_COLOR_AWIDTH-1:0] color_addr_t;
    typedef logic [`XR_TILE_AWIDTH-1:0] tile_addr_t;
    typedef logic [`XR_COPP_AWIDTH-1:0] copp_addr_t;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        DECODE,
        WRITE
    } copp_state_t;

    typedef enum logic {
        OFF,
        RUN
    } vid_state_t;

endpackage

`default_nettype wire

//--- verilog/xr_regs.sv
`default_nettype none

`include "xr_defs.svh"

module xr_regs (
    input  wire logic               clk,
    input  wire logic               rst_n_i,
    input  wire logic               xreg_wr_i,
    input  wire xr_pkg::xr_addr_t   xreg_addr_i,
    input  wire xr_pkg::xr_word_t   xreg_data_i,
    output xr_pkg::xr_word_t        xreg_data_o,
    output logic                    copp_en_o,
    output xr_pkg::copp_addr_t      copp_start_o,
    output logic                    vid_en_o,
    output xr_pkg::xr_word_t        vid_len_o
);

    // 0 copper control, 1 video control, 2 video length, 3..7 scratch
    xr_pkg::xr_word_t regs [8];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (xreg_wr_i) begin
            regs[xreg_addr_i[2:0]] <= xreg_data_i;
        end
    end

    assign xreg_data_o = regs[xreg_addr_i[2:0]];

    // copper enable in bit 0, start index above it
    assign copp_en_o    = regs[0][0];
    assign copp_start_o = regs[0][`XR_COPP_AWIDTH:1];

    assign vid_en_o  = regs[1][0];
    assign vid_len_o = regs[2];

endmodule

`default_nettype wire

//--- verilog/xr_subsys_top.sv
`default_nettype none

module xr_subsys_top (
    input  wire logic             clk,
    input  wire logic             rst_n_i,
    input  wire logic             xr_sel_i,
    input  wire logic             xr_wr_i,
    input  wire xr_pkg::xr_addr_t xr_addr_i,
    input  wire xr_pkg::xr_word_t xr_data_i,
    output logic                  xr_ack_o,
    output xr_pkg::xr_word_t      xr_data_o,
    output xr_pkg::xr_word_t      pixel_o,
    output xr_pkg::xr_word_t      pixel_b_o,
    output logic                  pixel_valid_o,
    output logic                  copper_busy_o
);

    // copper to arbiter
    logic                copp_xr_sel;
    logic                copp_xr_ack;
    xr_pkg::xr_addr_t    copp_xr_addr;
    xr_pkg::xr_word_t    copp_xr_data;
    logic                copp_prog_sel;
    xr_pkg::copp_addr_t  copp_prog_addr;
    xr_pkg::copp_word_t  copp_prog_data;

    // video fetch to arbiter
    logic                vid_tile_sel;
    xr_pkg::tile_addr_t  vid_tile_addr;
    xr_pkg::xr_word_t    vid_tile_data;
    logic                vid_color_sel;
    xr_pkg::color_addr_t vid_color_addr;
    xr_pkg::xr_word_t    vid_colora_data;
    xr_pkg::xr_word_t    vid_colorb_data;

    // register bus and control
    logic                xreg_wr;
    xr_pkg::xr_addr_t    xreg_addr;
    xr_pkg::xr_word_t    xreg_data_w;
    xr_pkg::xr_word_t    xreg_data_r;
    logic                copp_en;
    xr_pkg::copp_addr_t  copp_start;
    logic                vid_en;
    xr_pkg::xr_word_t    vid_len;

    xr_mem_arb u_xr_mem_arb (
        .clk(clk), .rst_n_i(rst_n_i),
        .xr_sel_i(xr_sel_i), .xr_wr_i(xr_wr_i),
        .xr_addr_i(xr_addr_i), .xr_data_i(xr_data_i),
        .xr_ack_o(xr_ack_o), .xr_data_o(xr_data_o),
        .copp_xr_sel_i(copp_xr_sel), .copp_xr_addr_i(copp_xr_addr),
        .copp_xr_data_i(copp_xr_data), .copp_xr_ack_o(copp_xr_ack),
        .copp_prog_sel_i(copp_prog_sel), .copp_prog_addr_i(copp_prog_addr),
        .copp_prog_data_o(copp_prog_data),
        .vid_tile_sel_i(vid_tile_sel), .vid_tile_addr_i(vid_tile_addr),
        .vid_tile_data_o(vid_tile_data),
        .vid_color_sel_i(vid_color_sel), .vid_color_addr_i(vid_color_addr),
        .vid_colora_data_o(vid_colora_data), .vid_colorb_data_o(vid_colorb_data),
        .xreg_wr_o(xreg_wr), .xreg_addr_o(xreg_addr),
        .xreg_data_o(xreg_data_w), .xreg_data_i(xreg_data_r)
    );

    xr_regs u_xr_regs (
        .clk(clk), .rst_n_i(rst_n_i),
        .xreg_wr_i(xreg_wr), .xreg_addr_i(xreg_addr),
        .xreg_data_i(xreg_data_w), .xreg_data_o(xreg_data_r),
        .copp_en_o(copp_en), .copp_start_o(copp_start),
        .vid_en_o(vid_en), .vid_len_o(vid_len)
    );

    copper u_copper (
        .clk(clk), .rst_n_i(rst_n_i),
        .copp_en_i(copp_en), .copp_start_i(copp_start),
        .copp_prog_sel_o(copp_prog_sel), .copp_prog_addr_o(copp_prog_addr),
        .copp_prog_data_i(copp_prog_data),
        .copp_xr_sel_o(copp_xr_sel), .copp_xr_addr_o(copp_xr_addr),
        .copp_xr_data_o(copp_xr_data), .copp_xr_ack_i(copp_xr_ack),
        .copper_busy_o(copper_busy_o)
    );

    video_fetch u_video_fetch (
        .clk(clk), .rst_n_i(rst_n_i),
        .vid_en_i(vid_en), .vid_len_i(vid_len),
        .tile_sel_o(vid_tile_sel), .tile_addr_o(vid_tile_addr),
        .tile_data_i(vid_tile_data),
        .color_sel_o(vid_color_sel), .color_addr_o(vid_color_addr),
        .colora_data_i(vid_colora_data), .colorb_data_i(vid_colorb_data),
        .pixel_o(pixel_o), .pixel_b_o(pixel_b_o), .pixel_valid_o(pixel_valid_o)
    );

endmodule

`default_nettype wire
